// File: rtl/rv_isa_pkg.sv
// rv64i isa package with widths, opcodes, alu operations and the decoded instruction
package rv_isa_pkg;

  localparam int XLEN  = 64;
  localparam int ILEN  = 32;
  localparam int NREGS = 32;

  typedef logic [XLEN-1:0] xlen_t;    // register value
  typedef logic [ILEN-1:0] inst_t;    // instruction word
  typedef logic [4:0]      reg_idx_t; // register index

  // major opcodes handled by this slice
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // sub and sra forms

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10  // lui
  } alu_op_e;

  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    xlen_t    imm;      // sign extended
    alu_op_e  alu_op;
    logic     use_imm;  // operand b from imm
    logic     word_op;  // 32-bit op, sext result
    logic     reg_wr;
    logic     illegal;
  } dec_t;

endpackage

// File: rtl/apb_bus_pkg.sv
// apb bus package with request and response structs, widths and the register map
package apb_bus_pkg;

  localparam int APB_AW = 8;
  localparam int APB_DW = 32;

  typedef logic [APB_AW-1:0] apb_addr_t;
  typedef logic [APB_DW-1:0] apb_data_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  localparam apb_addr_t REG_INST     = 8'h00; // wo, issues instruction
  localparam apb_addr_t REG_STATUS   = 8'h04; // ro, bit 0 sticky illegal
  localparam apb_addr_t REG_SEL      = 8'h08; // rw, readback index
  localparam apb_addr_t REG_RDATA_LO = 8'h0C; // ro
  localparam apb_addr_t REG_RDATA_HI = 8'h10; // ro

endpackage

// File: rtl/inst_decoder.sv
// instruction decoder for the rv64i integer subset, table style match per instruction
`timescale 1ns/10ps

module inst_decoder (
  input  rv_isa_pkg::inst_t i_inst,
  output rv_isa_pkg::dec_t  o_dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_isa_pkg::xlen_t imm_i;
  rv_isa_pkg::xlen_t imm_u;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};

  logic is_op, is_imm, is_op32, is_imm32;
  logic f7_base, f7_alt;

  assign is_op    = (opcode == rv_isa_pkg::OPC_OP);
  assign is_imm   = (opcode == rv_isa_pkg::OPC_OP_IMM);
  assign is_op32  = (opcode == rv_isa_pkg::OPC_OP_32);
  assign is_imm32 = (opcode == rv_isa_pkg::OPC_OP_IMM_32);
  assign f7_base  = (funct7 == rv_isa_pkg::F7_BASE);
  assign f7_alt   = (funct7 == rv_isa_pkg::F7_ALT);

  // lui and op-imm, 6-bit shamt so funct7[0] is free
  wire inst_lui   = (opcode == rv_isa_pkg::OPC_LUI);
  wire inst_addi  = is_imm & (funct3 == 3'b000);
  wire inst_slti  = is_imm & (funct3 == 3'b010);
  wire inst_sltiu = is_imm & (funct3 == 3'b011);
  wire inst_xori  = is_imm & (funct3 == 3'b100);
  wire inst_ori   = is_imm & (funct3 == 3'b110);
  wire inst_andi  = is_imm & (funct3 == 3'b111);
  wire inst_slli  = is_imm & (funct3 == 3'b001) & (funct7[6:1] == 6'b000000);
  wire inst_srli  = is_imm & (funct3 == 3'b101) & (funct7[6:1] == 6'b000000);
  wire inst_srai  = is_imm & (funct3 == 3'b101) & (funct7[6:1] == 6'b010000);

  // op
  wire inst_add   = is_op & (funct3 == 3'b000) & f7_base;
  wire inst_sub   = is_op & (funct3 == 3'b000) & f7_alt;
  wire inst_sll   = is_op & (funct3 == 3'b001) & f7_base;
  wire inst_slt   = is_op & (funct3 == 3'b010) & f7_base;
  wire inst_sltu  = is_op & (funct3 == 3'b011) & f7_base;
  wire inst_xor   = is_op & (funct3 == 3'b100) & f7_base;
  wire inst_srl   = is_op & (funct3 == 3'b101) & f7_base;
  wire inst_sra   = is_op & (funct3 == 3'b101) & f7_alt;
  wire inst_or    = is_op & (funct3 == 3'b110) & f7_base;
  wire inst_and   = is_op & (funct3 == 3'b111) & f7_base;

  // word forms
  wire inst_addiw = is_imm32 & (funct3 == 3'b000);
  wire inst_slliw = is_imm32 & (funct3 == 3'b001) & f7_base;
  wire inst_srliw = is_imm32 & (funct3 == 3'b101) & f7_base;
  wire inst_sraiw = is_imm32 & (funct3 == 3'b101) & f7_alt;
  wire inst_addw  = is_op32 & (funct3 == 3'b000) & f7_base;
  wire inst_subw  = is_op32 & (funct3 == 3'b000) & f7_alt;
  wire inst_sllw  = is_op32 & (funct3 == 3'b001) & f7_base;
  wire inst_srlw  = is_op32 & (funct3 == 3'b101) & f7_base;
  wire inst_sraw  = is_op32 & (funct3 == 3'b101) & f7_alt;

  wire type_i = |{inst_addi,  inst_slti,  inst_sltiu, inst_xori,  inst_ori,
                  inst_andi,  inst_slli,  inst_srli,  inst_srai,
                  inst_addiw, inst_slliw, inst_srliw, inst_sraiw};
  wire type_r = |{inst_add,   inst_sub,   inst_sll,   inst_slt,   inst_sltu,
                  inst_xor,   inst_srl,   inst_sra,   inst_or,    inst_and,
                  inst_addw,  inst_subw,  inst_sllw,  inst_srlw,  inst_sraw};

  // alu classes
  wire alu_add  = |{inst_addi, inst_add, inst_addiw, inst_addw};
  wire alu_sub  = |{inst_sub, inst_subw};
  wire alu_sll  = |{inst_slli, inst_sll, inst_slliw, inst_sllw};
  wire alu_slt  = |{inst_slti, inst_slt};
  wire alu_sltu = |{inst_sltiu, inst_sltu};
  wire alu_xor  = |{inst_xori, inst_xor};
  wire alu_srl  = |{inst_srli, inst_srl, inst_srliw, inst_srlw};
  wire alu_sra  = |{inst_srai, inst_sra, inst_sraiw, inst_sraw};
  wire alu_or   = |{inst_ori, inst_or};
  wire alu_and  = |{inst_andi, inst_and};

  wire any_alu  = |{inst_lui, alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                    alu_xor, alu_srl, alu_sra, alu_or, alu_and};

  always_comb begin
    o_dec.rs1     = i_inst[19:15];
    o_dec.rs2     = i_inst[24:20];
    o_dec.rd      = i_inst[11:7];
    o_dec.imm     = inst_lui ? imm_u : imm_i;
    o_dec.alu_op  = rv_isa_pkg::ALU_ADD;
    if (alu_sub)  o_dec.alu_op = rv_isa_pkg::ALU_SUB;
    if (alu_sll)  o_dec.alu_op = rv_isa_pkg::ALU_SLL;
    if (alu_slt)  o_dec.alu_op = rv_isa_pkg::ALU_SLT;
    if (alu_sltu) o_dec.alu_op = rv_isa_pkg::ALU_SLTU;
    if (alu_xor)  o_dec.alu_op = rv_isa_pkg::ALU_XOR;
    if (alu_srl)  o_dec.alu_op = rv_isa_pkg::ALU_SRL;
    if (alu_sra)  o_dec.alu_op = rv_isa_pkg::ALU_SRA;
    if (alu_or)   o_dec.alu_op = rv_isa_pkg::ALU_OR;
    if (alu_and)  o_dec.alu_op = rv_isa_pkg::ALU_AND;
    if (inst_lui) o_dec.alu_op = rv_isa_pkg::ALU_PASS_B;
    o_dec.use_imm = type_i | inst_lui;
    o_dec.word_op = |{inst_addiw, inst_slliw, inst_srliw, inst_sraiw,
                      inst_addw, inst_subw, inst_sllw, inst_srlw, inst_sraw};
    o_dec.reg_wr  = |{type_r, type_i, inst_lui};
    o_dec.illegal = !any_alu;
    // write class and alu class tables must agree
    assert (!(o_dec.illegal === 1'b1 && o_dec.reg_wr === 1'b1));
  end

endmodule

// File: rtl/int_alu.sv
// integer alu, 64-bit operations with a 32-bit word mode that sign extends its result
`timescale 1ns/10ps

module int_alu (
  input  rv_isa_pkg::alu_op_e i_op,
  input  logic                i_word,
  input  rv_isa_pkg::xlen_t   i_a,
  input  rv_isa_pkg::xlen_t   i_b,
  output rv_isa_pkg::xlen_t   o_result
);

  logic [5:0]        shamt;
  rv_isa_pkg::xlen_t a_srl;
  rv_isa_pkg::xlen_t a_sra;
  rv_isa_pkg::xlen_t raw;

  always_comb begin
    shamt = i_word ? {1'b0, i_b[4:0]} : i_b[5:0];
    a_srl = i_word ? {32'b0, i_a[31:0]} : i_a;           // zero fill above bit 31
    a_sra = i_word ? {{32{i_a[31]}}, i_a[31:0]} : i_a;   // sign from bit 31
    case (i_op)
      rv_isa_pkg::ALU_ADD:    raw = i_a + i_b;
      rv_isa_pkg::ALU_SUB:    raw = i_a - i_b;
      rv_isa_pkg::ALU_SLL:    raw = i_a << shamt;
      rv_isa_pkg::ALU_SLT:    raw = {63'b0, $signed(i_a) < $signed(i_b)};
      rv_isa_pkg::ALU_SLTU:   raw = {63'b0, i_a < i_b};
      rv_isa_pkg::ALU_XOR:    raw = i_a ^ i_b;
      rv_isa_pkg::ALU_SRL:    raw = a_srl >> shamt;
      rv_isa_pkg::ALU_SRA:    raw = $signed(a_sra) >>> shamt;
      rv_isa_pkg::ALU_OR:     raw = i_a | i_b;
      rv_isa_pkg::ALU_AND:    raw = i_a & i_b;
      rv_isa_pkg::ALU_PASS_B: raw = i_b;
      default:                raw = '0;
    endcase
    o_result = i_word ? {{32{raw[31]}}, raw[31:0]} : raw;
  end

  // decoder must only hand over defined operations
  always_comb begin
    assert (i_op inside {rv_isa_pkg::ALU_ADD, rv_isa_pkg::ALU_SUB, rv_isa_pkg::ALU_SLL,
                         rv_isa_pkg::ALU_SLT, rv_isa_pkg::ALU_SLTU, rv_isa_pkg::ALU_XOR,
                         rv_isa_pkg::ALU_SRL, rv_isa_pkg::ALU_SRA, rv_isa_pkg::ALU_OR,
                         rv_isa_pkg::ALU_AND, rv_isa_pkg::ALU_PASS_B});
  end

endmodule

// File: rtl/reg_file.sv
// integer register file, 32 x 64 bits, two async read ports and one sync write port
`timescale 1ns/10ps

module reg_file (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  rv_isa_pkg::reg_idx_t i_raddr_a,
  input  rv_isa_pkg::reg_idx_t i_raddr_b,
  input  rv_isa_pkg::reg_idx_t i_waddr,
  input  logic                 i_we,
  input  rv_isa_pkg::xlen_t    i_wdata,
  output rv_isa_pkg::xlen_t    o_rdata_a,
  output rv_isa_pkg::xlen_t    o_rdata_b
);

  rv_isa_pkg::xlen_t regs [rv_isa_pkg::NREGS];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < rv_isa_pkg::NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != '0)) begin // x0 stays zero
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata_a = regs[i_raddr_a];
  assign o_rdata_b = regs[i_raddr_b];

endmodule

// File: rtl/apb_exec_ctrl.sv
// apb slave controller, register map, instruction issue fsm and writeback control
`timescale 1ns/10ps

module apb_exec_ctrl (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  apb_bus_pkg::apb_req_t i_apb,
  output apb_bus_pkg::apb_rsp_t o_apb,
  output rv_isa_pkg::inst_t     o_inst,
  input  rv_isa_pkg::dec_t      i_dec,
  output rv_isa_pkg::reg_idx_t  o_raddr_a,
  output rv_isa_pkg::reg_idx_t  o_raddr_b,
  input  rv_isa_pkg::xlen_t     i_rdata_a,
  input  rv_isa_pkg::xlen_t     i_rdata_b,
  output rv_isa_pkg::xlen_t     o_alu_b,
  input  rv_isa_pkg::xlen_t     i_result,
  output logic                  o_we,
  output rv_isa_pkg::reg_idx_t  o_waddr,
  output rv_isa_pkg::xlen_t     o_wdata
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LATCH,
    ST_EXEC
  } state_e;

  state_e                state_q, state_d;
  rv_isa_pkg::inst_t     inst_q;
  rv_isa_pkg::reg_idx_t  sel_q;
  logic                  sticky_q;
  logic                  setup, access, inst_wr, idle_acc;
  logic                  map_err, ready;
  apb_bus_pkg::apb_data_t reg_rdata;

  assign setup    = i_apb.psel && !i_apb.penable;
  assign access   = i_apb.psel && i_apb.penable;
  assign inst_wr  = i_apb.pwrite && (i_apb.paddr == apb_bus_pkg::REG_INST);
  assign idle_acc = (state_q == ST_IDLE) && access && !inst_wr; // zero wait state access

  // register map
  always_comb begin
    reg_rdata = '0;
    map_err   = 1'b0;
    case (i_apb.paddr)
      apb_bus_pkg::REG_INST:     map_err = !i_apb.pwrite;
      apb_bus_pkg::REG_STATUS: begin
        reg_rdata = {31'b0, sticky_q};
        map_err   = i_apb.pwrite;
      end
      apb_bus_pkg::REG_SEL:      reg_rdata = apb_bus_pkg::apb_data_t'(sel_q);
      apb_bus_pkg::REG_RDATA_LO: begin
        reg_rdata = i_rdata_a[31:0];
        map_err   = i_apb.pwrite;
      end
      apb_bus_pkg::REG_RDATA_HI: begin
        reg_rdata = i_rdata_a[63:32];
        map_err   = i_apb.pwrite;
      end
      default:                   map_err = 1'b1; // unmapped
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (setup && inst_wr) state_d = ST_LATCH;
      ST_LATCH: state_d = ST_EXEC;
      ST_EXEC:  state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q  <= ST_IDLE;
      sel_q    <= '0;
      sticky_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (idle_acc && i_apb.pwrite && (i_apb.paddr == apb_bus_pkg::REG_SEL)) begin
        sel_q <= i_apb.pwdata[4:0];
      end
      if ((state_q == ST_EXEC) && i_dec.illegal) begin
        sticky_q <= 1'b1;
      end else if (idle_acc && !i_apb.pwrite && (i_apb.paddr == apb_bus_pkg::REG_STATUS)) begin
        sticky_q <= 1'b0; // clear on read
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (state_q == ST_LATCH) inst_q <= i_apb.pwdata; // first access cycle
  end

  assign ready         = (state_q == ST_EXEC) || idle_acc;
  assign o_apb.pready  = ready;
  assign o_apb.pslverr = (state_q == ST_EXEC) ? i_dec.illegal : (ready && map_err);
  assign o_apb.prdata  = (idle_acc && !i_apb.pwrite) ? reg_rdata : '0;

  assign o_inst    = inst_q;
  assign o_raddr_a = (state_q == ST_EXEC) ? i_dec.rs1 : sel_q;
  assign o_raddr_b = (state_q == ST_EXEC) ? i_dec.rs2 : sel_q;
  assign o_alu_b   = i_dec.use_imm ? i_dec.imm : i_rdata_b;
  assign o_we      = (state_q == ST_EXEC) && i_dec.reg_wr;
  assign o_waddr   = i_dec.rd;
  assign o_wdata   = i_result;

  // pready only answers an access phase, also across the two-cycle issue
  assert property (@(posedge i_clk) disable iff (i_reset)
    o_apb.pready |-> (i_apb.psel && i_apb.penable));

  // host holds the transfer while pready is low
  assert property (@(posedge i_clk) disable iff (i_reset)
    (state_q == ST_EXEC) |-> $stable(i_apb));

endmodule

// File: rtl/exec_unit_top.sv
// rv64i decode and execute slice top, apb controller with decoder, register file and alu
`timescale 1ns/10ps

module exec_unit_top (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  apb_bus_pkg::apb_req_t i_apb,
  output apb_bus_pkg::apb_rsp_t o_apb
);

  rv_isa_pkg::inst_t    inst;
  rv_isa_pkg::dec_t     dec;
  rv_isa_pkg::reg_idx_t raddr_a, raddr_b, waddr;
  rv_isa_pkg::xlen_t    rdata_a, rdata_b, alu_b, result, wdata;
  logic                 we;

  apb_exec_ctrl u_ctrl (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_apb     (i_apb),
    .o_apb     (o_apb),
    .o_inst    (inst),
    .i_dec     (dec),
    .o_raddr_a (raddr_a),
    .o_raddr_b (raddr_b),
    .i_rdata_a (rdata_a),
    .i_rdata_b (rdata_b),
    .o_alu_b   (alu_b),
    .i_result  (result),
    .o_we      (we),
    .o_waddr   (waddr),
    .o_wdata   (wdata)
  );

  inst_decoder u_dec (
    .i_inst (inst),
    .o_dec  (dec)
  );

  reg_file u_rf (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_raddr_a (raddr_a),
    .i_raddr_b (raddr_b),
    .i_waddr   (waddr),
    .i_we      (we),
    .i_wdata   (wdata),
    .o_rdata_a (rdata_a),
    .o_rdata_b (rdata_b)
  );

  int_alu u_alu (
    .i_op     (dec.alu_op),
    .i_word   (dec.word_op),
    .i_a      (rdata_a),
    .i_b      (alu_b),
    .o_result (result)
  );

endmodule

// File: bench/tb_exec_unit.sv
// testbench for the rv64i execute slice driving the apb port against a shadow register model
`timescale 1ns/10ps

module tb_exec_unit;

  localparam int PERIOD = 8;
  localparam int N_RAND = 150;
  localparam int N_WORD = 54;
  // fixed transfers of all tests plus four per random instruction
  localparam int N_XFERS = 281 + 4 * (N_RAND + N_WORD);

  localparam logic [31:0] CONSTS [5] = '{32'h12345678, 32'hdeadbeef, 32'h00000800,
                                         32'hfffff001, 32'h80000000};
  localparam logic [31:0] BAD [4] = '{
    {12'h000, 5'd5, 3'd3, 5'd7, 7'b0000011},         // ld
    {7'h00, 5'd6, 5'd5, 3'd0, 5'd8, 7'b1100011},     // beq
    {7'h01, 5'd6, 5'd5, 3'd0, 5'd9, 7'b0110011},     // mul
    {6'b010001, 6'd3, 5'd5, 3'd5, 5'd10, 7'b0010011} // srai with bad funct7
  };
  localparam logic [6:0] W_F7 [9] = '{7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h20, 7'h00,
                                      7'h00, 7'h20};
  localparam logic [2:0] W_F3 [9] = '{3'd0, 3'd1, 3'd5, 3'd5, 3'd0, 3'd0, 3'd1, 3'd5, 3'd5};

  typedef logic [63:0] shadow_t [32];

  logic                  clk;
  logic                  rst;
  apb_bus_pkg::apb_req_t apb_req;
  apb_bus_pkg::apb_rsp_t apb_rsp;
  shadow_t               shadow;
  integer                seed = 72;
  int                    cycles = 0, errors = 0, checks = 0;
  int                    tests = 0, bad_tests = 0, mark = 0;

  exec_unit_top UUT (
    .i_clk   (clk),
    .i_reset (rst),
    .i_apb   (apb_req),
    .o_apb   (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((N_XFERS * 10 + 10) * PERIOD);
    $display("watchdog expired, the DUT stopped answering apb transfers");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic logic [31:0] make_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] make_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] make_u(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // expected rd value by the rv64i rules and whether the encoding is supported
  function automatic logic ref_exec(input logic [31:0] inst, input shadow_t regs,
                                    output logic [63:0] val, output logic [4:0] rd);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        opi;
    logic        wrd;
    logic        alt;
    logic        ok;
    logic [5:0]  sh;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    opc = inst[6:0];
    f3  = inst[14:12];
    f7  = inst[31:25];
    rd  = inst[11:7];
    opi = (opc == 7'b0010011) || (opc == 7'b0011011);
    wrd = (opc == 7'b0111011) || (opc == 7'b0011011);
    alt = inst[30] && (!opi || f3 == 3'd5); // sub and sra forms
    a   = regs[inst[19:15]];
    b   = opi ? {{52{inst[31]}}, inst[31:20]} : regs[inst[24:20]];
    sh  = wrd ? {1'b0, b[4:0]} : b[5:0];
    case (opc)
      7'b0110111: ok = 1'b1;
      7'b0010011: ok = (f3 == 3'd1) ? (inst[31:26] == 6'h00) :
                       (f3 == 3'd5) ? (inst[31:26] == 6'h00 || inst[31:26] == 6'h10) : 1'b1;
      7'b0110011: ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      7'b0011011: ok = (f3 == 3'd0) || (f3 == 3'd1 && f7 == 7'h00) ||
                       (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
      7'b0111011: ok = (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5) &&
                       (f7 == 7'h00 || (f7 == 7'h20 && f3 != 3'd1));
      default:    ok = 1'b0;
    endcase
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << sh;
      3'd2: r = {63'h0, $signed(a) < $signed(b)};
      3'd3: r = {63'h0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        a = wrd ? {{32{alt & a[31]}}, a[31:0]} : a; // word source sign extended only for sra
        r = (a >> sh) | (~({64{1'b1}} >> sh) & {64{alt & a[63]}});
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    val = (opc == 7'b0110111) ? {{32{inst[31]}}, inst[31:12], 12'h000} :
          wrd ? {{32{r[31]}}, r[31:0]} : r;
    return ok;
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic apb_access(input logic wr, input apb_bus_pkg::apb_addr_t addr,
      input apb_bus_pkg::apb_data_t wdata, output apb_bus_pkg::apb_data_t rdata,
      output logic err);
    logic ready;
    @(posedge clk);
    #1;
    apb_req.psel    = 1'b1; // setup
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    cycles = 0;
    do begin
      @(negedge clk); // response settled mid cycle
      cycles++;
      ready = apb_rsp.pready;
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk);
    end while (!ready);
    #1;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input apb_bus_pkg::apb_addr_t addr,
      input apb_bus_pkg::apb_data_t data, output logic err);
    apb_bus_pkg::apb_data_t unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input apb_bus_pkg::apb_addr_t addr,
      output apb_bus_pkg::apb_data_t data, output logic err);
    apb_access(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic read_reg(input logic [4:0] idx, output logic [63:0] val);
    logic [31:0] lo;
    logic [31:0] hi;
    logic        e0, e1, e2;
    apb_write(apb_bus_pkg::REG_SEL, {27'h0, idx}, e0);
    compare("sel write cycles", 64'(cycles), 64'd1);
    apb_read(apb_bus_pkg::REG_RDATA_LO, lo, e1);
    compare("rdata_lo read cycles", 64'(cycles), 64'd1);
    apb_read(apb_bus_pkg::REG_RDATA_HI, hi, e2);
    compare("rdata_hi read cycles", 64'(cycles), 64'd1);
    compare("readback pslverr", {61'h0, e0, e1, e2}, 64'h0);
    val = {hi, lo};
  endtask

  task automatic check_reg(input logic [4:0] idx);
    logic [63:0] val;
    read_reg(idx, val);
    compare($sformatf("x%0d", idx), val, shadow[idx]);
  endtask

  task automatic check_all();
    for (int i = 1; i < 32; i++) check_reg(i[4:0]);
  endtask

  task automatic issue(input logic [31:0] inst);
    logic [63:0] val;
    logic [4:0]  rd;
    logic        ok;
    logic        err;
    ok = ref_exec(inst, shadow, val, rd);
    apb_write(apb_bus_pkg::REG_INST, inst, err);
    compare($sformatf("pslverr of inst 0x%h", inst), {63'h0, err}, {63'h0, !ok});
    compare("inst access cycles", 64'(cycles), 64'd2);
    if (ok && rd != 5'd0) shadow[rd] = val;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors != mark) bad_tests++;
    $display("test %0d %s: %s", tests, name, (errors == mark) ? "ok" : "FAILED");
    mark = errors;
  endtask

  initial begin
    logic [63:0] v;
    logic [31:0] r;
    logic [31:0] c;
    logic [31:0] d;
    logic        e;
    int          k;
    rst     = 1'b1;
    apb_req = '0;
    foreach (shadow[i]) shadow[i] = 64'h0;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;

    apb_read(apb_bus_pkg::REG_STATUS, d, e);
    compare("status", {31'h0, e, d}, 64'h0);
    check_all();
    finish_test("reset state");

    for (int i = 0; i < 5; i++) begin
      c = CONSTS[i];
      issue(make_u(c[31:12] + {19'h0, c[11]}, 5'd5 + i[4:0], 7'b0110111)); // round for addi
      issue(make_i(c[11:0], 5'd5 + i[4:0], 3'd0, 5'd5 + i[4:0], 7'b0010011));
      read_reg(5'd5 + i[4:0], v);
      compare($sformatf("x%0d constant", 5 + i), v, {{32{c[31]}}, c});
      compare($sformatf("x%0d shadow", 5 + i), v, shadow[5 + i]);
    end
    finish_test("lui addi constants");

    for (int i = 1; i < 32; i++) begin
      r = rnd();
      issue(make_u(r[31:12], i[4:0], 7'b0110111)); // spread register contents
    end
    for (int n = 0; n < N_RAND; n++) begin
      r = rnd();
      d = rnd();
      if (r[0]) begin
        c = make_r({1'b0, r[1] & (r[4:2] == 3'd0 || r[4:2] == 3'd5), 5'h0},
                   d[24:20], d[19:15], r[4:2], d[11:7], 7'b0110011);
      end else begin
        c = make_i(d[31:20], d[19:15], r[4:2], d[11:7], 7'b0010011);
        if (r[4:2] == 3'd1 || r[4:2] == 3'd5) c[31:26] = {1'b0, r[1] & r[4], 4'h0};
      end
      issue(c);
      check_reg(c[11:7]);
    end
    finish_test("random op and op-imm");

    issue(make_u(20'h80000, 5'd20, 7'b0110111));
    issue(make_i(12'hfff, 5'd20, 3'd0, 5'd20, 7'b0010011));
    issue(make_i(12'h001, 5'd20, 3'd0, 5'd21, 7'b0011011)); // wraps into bit 31
    read_reg(5'd21, v);
    compare("x21 addiw", v, 64'hffffffff80000000);
    for (int n = 0; n < N_WORD; n++) begin
      d = rnd();
      k = n % 9;
      if (k == 0)
        c = make_i(d[31:20], d[19:15], 3'd0, d[11:7], 7'b0011011);
      else if (k < 4)
        c = make_i({W_F7[k], d[24:20]}, d[19:15], W_F3[k], d[11:7], 7'b0011011);
      else
        c = make_r(W_F7[k], d[24:20], d[19:15], W_F3[k], d[11:7], 7'b0111011);
      issue(c);
      check_reg(c[11:7]);
    end
    issue(make_r(7'h00, 5'd21, 5'd20, 3'd0, 5'd0, 7'b0111011));
    issue(make_i(12'h403, 5'd21, 3'd5, 5'd0, 7'b0011011));
    check_reg(5'd0);
    finish_test("word instructions");

    for (int i = 0; i < 4; i++) begin
      issue(BAD[i]);
      check_reg(BAD[i][11:7]);
      apb_read(apb_bus_pkg::REG_STATUS, d, e);
      compare("status after illegal", {31'h0, e, d}, 64'h1);
      apb_read(apb_bus_pkg::REG_STATUS, d, e);
      compare("status second read", {31'h0, e, d}, 64'h0);
    end
    finish_test("illegal encodings");

    apb_read(8'h20, d, e);
    compare("unmapped read pslverr", {63'h0, e}, 64'h1);
    compare("unmapped read cycles", 64'(cycles), 64'd1);
    apb_write(apb_bus_pkg::REG_RDATA_LO, 32'hffffffff, e);
    compare("rdata_lo write pslverr", {63'h0, e}, 64'h1);
    compare("rdata_lo write cycles", 64'(cycles), 64'd1);
    apb_read(apb_bus_pkg::REG_INST, d, e);
    compare("inst read pslverr", {63'h0, e}, 64'h1);
    compare("inst read cycles", 64'(cycles), 64'd1);
    check_all();
    finish_test("bus errors");

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, bad_tests, checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: list.f
rtl/rv_isa_pkg.sv
rtl/apb_bus_pkg.sv
rtl/inst_decoder.sv
rtl/int_alu.sv
rtl/reg_file.sv
rtl/apb_exec_ctrl.sv
rtl/exec_unit_top.sv
bench/tb_exec_unit.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_exec_unit
FILELIST  = list.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJDIR)
